// ==== design/ethft_params.svh ====
`ifndef ETHFT_PARAMS_SVH
`define ETHFT_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths

// One GMII byte lane
`define ETH_DATA_W 8

// Speed code as reported by the PHY status pins
`define ETH_SPEED_W 2

////////////////////////////////////////////////////////////////////////////
// Link qualification

// Consecutive stable samples before a new raw link report is accepted
`define LINK_STABLE_CYCLES 16

// Debounce counter width, must hold LINK_STABLE_CYCLES
`define LINK_CNT_W 5

`endif

// ==== design/ethft_pkg.sv ====
`include "ethft_params.svh"

package ethft_pkg;

	// One byte on the GMII data lane
	typedef logic [`ETH_DATA_W-1:0] eth_byte_t;

	// Speed code of a PHY
	typedef enum logic [`ETH_SPEED_W-1:0] {
		SPEED_10   = 0,
		SPEED_100  = 1,
		SPEED_1000 = 2
	} speed_e;

	// Index of one of the two redundant PHYs
	typedef logic port_t;

	// Byte lane shared by receive and transmit
	// en carries rxdv on receive and txen on transmit
	typedef struct packed {
		eth_byte_t data;
		logic      en;
		logic      er;
	} gmii_lane_t;

endpackage

// ==== design/link_status_if.sv ====
`timescale 1ns/100ps

interface link_status_if;

	import ethft_pkg::*;

	// Qualified link state of both PHYs
	logic   phy0_up;
	speed_e phy0_speed;
	logic   phy1_up;
	speed_e phy1_speed;

	// Debounce side
	modport monitor (
		output phy0_up,
		output phy0_speed,
		output phy1_up,
		output phy1_speed
	);

	// Failover decision side
	modport arbiter (
		input phy0_up,
		input phy0_speed,
		input phy1_up,
		input phy1_speed
	);

endinterface

// ==== design/link_monitor.sv ====
`timescale 1ns/100ps
`include "ethft_params.svh"

module link_monitor (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              phy0_up_i,
	input  ethft_pkg::speed_e phy0_speed_i,
	input  logic              phy1_up_i,
	input  ethft_pkg::speed_e phy1_speed_i,
	link_status_if.monitor    status_o
);

	import ethft_pkg::*;

	localparam logic [`LINK_CNT_W-1:0] stable_cnt = `LINK_STABLE_CYCLES;
	localparam logic [`LINK_CNT_W-1:0] first_cnt  = 1;

	logic   raw_up [2];
	speed_e raw_speed [2];
	logic   qual_up [2];
	speed_e qual_speed [2];

	assign raw_up[0]    = phy0_up_i;
	assign raw_speed[0] = phy0_speed_i;
	assign raw_up[1]    = phy1_up_i;
	assign raw_speed[1] = phy1_speed_i;

	////////////////////////////////////////////////////////////////////////////
	// Per port debounce

	for (genvar i = 0; i < 2; i++) begin : g_port
		logic                   last_up;
		speed_e                 last_speed;
		logic [`LINK_CNT_W-1:0] cnt;
		logic [`LINK_CNT_W-1:0] cnt_next;
		logic                   raw_moved;
		logic                   raw_new;

		// Raw report differs from the previous sample
		assign raw_moved = (raw_up[i] != last_up) || (raw_speed[i] != last_speed);

		// Raw report differs from what downstream sees
		assign raw_new = (raw_up[i] != qual_up[i]) || (raw_speed[i] != qual_speed[i]);

		// A moved report counts this edge as its first stable sample
		always_comb begin
			if (raw_moved) begin
				cnt_next = first_cnt;
			end else if (cnt == stable_cnt) begin
				cnt_next = cnt;
			end else begin
				cnt_next = cnt + 1'b1;
			end
		end

		always_ff @(posedge clk) begin
			if (reset_i) begin
				last_up       <= 1'b0;
				last_speed    <= SPEED_10;
				cnt           <= '0;
				qual_up[i]    <= 1'b0;
				qual_speed[i] <= SPEED_10;
			end else begin
				last_up    <= raw_up[i];
				last_speed <= raw_speed[i];
				cnt        <= cnt_next;
				// Accept on the edge the report completes its stable run
				if (raw_new && (cnt_next == stable_cnt)) begin
					qual_up[i]    <= raw_up[i];
					qual_speed[i] <= raw_speed[i];
				end
			end
		end
	end

	// Qualified state toward the arbiter
	assign status_o.phy0_up    = qual_up[0];
	assign status_o.phy0_speed = qual_speed[0];
	assign status_o.phy1_up    = qual_up[1];
	assign status_o.phy1_speed = qual_speed[1];

endmodule

// ==== design/port_arbiter.sv ====
`timescale 1ns/100ps

module port_arbiter (
	input  logic              clk,
	input  logic              reset_i,
	link_status_if.arbiter    status_i,
	input  logic              phy0_rxdv_i,
	input  logic              phy1_rxdv_i,
	output ethft_pkg::port_t  active_port_o,
	output logic              link_up_o,
	output ethft_pkg::speed_e speed_o,
	output logic              link_change_o
);

	import ethft_pkg::*;

	port_t  active_q;
	logic   link_up_q;
	speed_e speed_q;
	logic   change_q;

	logic   cur_up;
	logic   other_up;
	logic   cur_rxdv;
	port_t  active_next;
	logic   link_up_next;
	speed_e speed_next;

	// Views relative to the port currently active
	assign cur_up   = active_q ? status_i.phy1_up : status_i.phy0_up;
	assign other_up = active_q ? status_i.phy0_up : status_i.phy1_up;
	assign cur_rxdv = active_q ? phy1_rxdv_i : phy0_rxdv_i;

	// A port with link is never abandoned
	// Failover waits for the failing port to sit between frames
	always_comb begin
		active_next = active_q;
		if (!cur_up && other_up && !cur_rxdv) begin
			active_next = ~active_q;
		end
	end

	// Merged status follows the port chosen on this edge
	assign link_up_next = active_next ? status_i.phy1_up : status_i.phy0_up;

	always_comb begin
		if (!link_up_next) begin
			speed_next = SPEED_10;
		end else if (active_next) begin
			speed_next = status_i.phy1_speed;
		end else begin
			speed_next = status_i.phy0_speed;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			active_q  <= 1'b0;
			link_up_q <= 1'b0;
			speed_q   <= SPEED_10;
			change_q  <= 1'b0;
		end else begin
			active_q  <= active_next;
			link_up_q <= link_up_next;
			speed_q   <= speed_next;
			// Pulse lines up with the first cycle of the new state
			change_q  <= (link_up_next != link_up_q) || (active_next != active_q);
		end
	end

	assign active_port_o = active_q;
	assign link_up_o     = link_up_q;
	assign speed_o       = speed_q;
	assign link_change_o = change_q;

endmodule

// ==== design/rx_merge.sv ====
`timescale 1ns/100ps

module rx_merge (
	input  logic                  clk,
	input  logic                  reset_i,
	input  ethft_pkg::gmii_lane_t phy0_rx_i,
	input  ethft_pkg::gmii_lane_t phy1_rx_i,
	input  ethft_pkg::port_t      active_port_i,
	input  logic                  link_up_i,
	output ethft_pkg::gmii_lane_t mac_rx_o
);

	import ethft_pkg::*;

	gmii_lane_t sel_lane;
	eth_byte_t  data_q;
	logic       dv_q;
	logic       er_q;

	// Active port lane, blanked while no port has link
	always_comb begin
		if (!link_up_i) begin
			sel_lane = '0;
		end else if (active_port_i) begin
			sel_lane = phy1_rx_i;
		end else begin
			sel_lane = phy0_rx_i;
		end
	end

	// Frame control toward the MAC
	always_ff @(posedge clk) begin
		if (reset_i) begin
			dv_q <= 1'b0;
			er_q <= 1'b0;
		end else begin
			dv_q <= sel_lane.en;
			er_q <= sel_lane.er;
		end
	end

	// Payload byte
	always_ff @(posedge clk) begin
		data_q <= sel_lane.data;
	end

	assign mac_rx_o = '{data: data_q, en: dv_q, er: er_q};

endmodule

// ==== design/tx_steer.sv ====
`timescale 1ns/100ps

module tx_steer (
	input  logic                  clk,
	input  logic                  reset_i,
	input  ethft_pkg::gmii_lane_t mac_tx_i,
	input  ethft_pkg::port_t      active_port_i,
	input  logic                  link_up_i,
	output ethft_pkg::gmii_lane_t phy0_tx_o,
	output ethft_pkg::gmii_lane_t phy1_tx_o
);

	import ethft_pkg::*;

	gmii_lane_t tx_lane [2];

	for (genvar p = 0; p < 2; p++) begin : g_port
		logic      sel;
		eth_byte_t data_q;
		logic      en_q;
		logic      er_q;

		// Only the active port of a live link carries MAC traffic
		assign sel = link_up_i && (active_port_i == port_t'(p));

		always_ff @(posedge clk) begin
			if (reset_i) begin
				en_q <= 1'b0;
				er_q <= 1'b0;
			end else begin
				en_q <= sel && mac_tx_i.en;
				er_q <= sel && mac_tx_i.er;
			end
		end

		// Idle port sees a zero byte
		always_ff @(posedge clk) begin
			data_q <= sel ? mac_tx_i.data : '0;
		end

		assign tx_lane[p] = '{data: data_q, en: en_q, er: er_q};
	end

	assign phy0_tx_o = tx_lane[0];
	assign phy1_tx_o = tx_lane[1];

endmodule

// ==== design/phy_failover_top.sv ====
`timescale 1ns/100ps
`include "ethft_params.svh"

module phy_failover_top (
	input  logic                    clk,
	input  logic                    reset_i,

	// PHY 0
	input  logic                    phy0_up_i,
	input  logic [`ETH_SPEED_W-1:0] phy0_speed_i,
	input  logic [`ETH_DATA_W-1:0]  phy0_rxdat_i,
	input  logic                    phy0_rxdv_i,
	input  logic                    phy0_rxer_i,
	output logic [`ETH_DATA_W-1:0]  phy0_txdat_o,
	output logic                    phy0_txen_o,
	output logic                    phy0_txer_o,

	// PHY 1
	input  logic                    phy1_up_i,
	input  logic [`ETH_SPEED_W-1:0] phy1_speed_i,
	input  logic [`ETH_DATA_W-1:0]  phy1_rxdat_i,
	input  logic                    phy1_rxdv_i,
	input  logic                    phy1_rxer_i,
	output logic [`ETH_DATA_W-1:0]  phy1_txdat_o,
	output logic                    phy1_txen_o,
	output logic                    phy1_txer_o,

	// MAC side
	output logic [`ETH_DATA_W-1:0]  mac_rxdat_o,
	output logic                    mac_rxdv_o,
	output logic                    mac_rxer_o,
	input  logic [`ETH_DATA_W-1:0]  mac_txdat_i,
	input  logic                    mac_txen_i,
	input  logic                    mac_txer_i,

	// Merged link status
	output logic                    link_up_o,
	output logic [`ETH_SPEED_W-1:0] speed_o,
	output logic                    active_port_o,
	output logic                    link_change_o
);

	import ethft_pkg::*;

	speed_e     phy0_speed;
	speed_e     phy1_speed;
	gmii_lane_t phy0_rx;
	gmii_lane_t phy1_rx;
	gmii_lane_t phy0_tx;
	gmii_lane_t phy1_tx;
	gmii_lane_t mac_rx;
	gmii_lane_t mac_tx;
	port_t      active_port;
	logic       link_up;
	speed_e     merged_speed;

	link_status_if link_status ();

	////////////////////////////////////////////////////////////////////////////
	// Lane packing

	assign phy0_speed = speed_e'(phy0_speed_i);
	assign phy1_speed = speed_e'(phy1_speed_i);

	assign phy0_rx = '{data: phy0_rxdat_i, en: phy0_rxdv_i, er: phy0_rxer_i};
	assign phy1_rx = '{data: phy1_rxdat_i, en: phy1_rxdv_i, er: phy1_rxer_i};
	assign mac_tx  = '{data: mac_txdat_i, en: mac_txen_i, er: mac_txer_i};

	assign phy0_txdat_o = phy0_tx.data;
	assign phy0_txen_o  = phy0_tx.en;
	assign phy0_txer_o  = phy0_tx.er;
	assign phy1_txdat_o = phy1_tx.data;
	assign phy1_txen_o  = phy1_tx.en;
	assign phy1_txer_o  = phy1_tx.er;

	assign mac_rxdat_o = mac_rx.data;
	assign mac_rxdv_o  = mac_rx.en;
	assign mac_rxer_o  = mac_rx.er;

	assign link_up_o     = link_up;
	assign speed_o       = merged_speed;
	assign active_port_o = active_port;

	////////////////////////////////////////////////////////////////////////////
	// Link qualification and port choice

	link_monitor link_monitor_i (
		.clk          (clk),
		.reset_i      (reset_i),
		.phy0_up_i    (phy0_up_i),
		.phy0_speed_i (phy0_speed),
		.phy1_up_i    (phy1_up_i),
		.phy1_speed_i (phy1_speed),
		.status_o     (link_status)
	);

	// Raw rxdv holds off failover until the frame ends
	port_arbiter port_arbiter_i (
		.clk           (clk),
		.reset_i       (reset_i),
		.status_i      (link_status),
		.phy0_rxdv_i   (phy0_rxdv_i),
		.phy1_rxdv_i   (phy1_rxdv_i),
		.active_port_o (active_port),
		.link_up_o     (link_up),
		.speed_o       (merged_speed),
		.link_change_o (link_change_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Data stages

	rx_merge rx_merge_i (
		.clk           (clk),
		.reset_i       (reset_i),
		.phy0_rx_i     (phy0_rx),
		.phy1_rx_i     (phy1_rx),
		.active_port_i (active_port),
		.link_up_i     (link_up),
		.mac_rx_o      (mac_rx)
	);

	tx_steer tx_steer_i (
		.clk           (clk),
		.reset_i       (reset_i),
		.mac_tx_i      (mac_tx),
		.active_port_i (active_port),
		.link_up_i     (link_up),
		.phy0_tx_o     (phy0_tx),
		.phy1_tx_o     (phy1_tx)
	);

endmodule

// ==== dv/tb_phy_failover.sv ====
`timescale 1ns/100ps
`include "ethft_params.svh"

module tb_phy_failover;

	import ethft_pkg::*;

	logic                    clk;
	logic                    reset_i;
	logic                    phy0_up_i;
	logic [`ETH_SPEED_W-1:0] phy0_speed_i;
	logic [`ETH_DATA_W-1:0]  phy0_rxdat_i;
	logic                    phy0_rxdv_i;
	logic                    phy0_rxer_i;
	logic [`ETH_DATA_W-1:0]  phy0_txdat_o;
	logic                    phy0_txen_o;
	logic                    phy0_txer_o;
	logic                    phy1_up_i;
	logic [`ETH_SPEED_W-1:0] phy1_speed_i;
	logic [`ETH_DATA_W-1:0]  phy1_rxdat_i;
	logic                    phy1_rxdv_i;
	logic                    phy1_rxer_i;
	logic [`ETH_DATA_W-1:0]  phy1_txdat_o;
	logic                    phy1_txen_o;
	logic                    phy1_txer_o;
	logic [`ETH_DATA_W-1:0]  mac_rxdat_o;
	logic                    mac_rxdv_o;
	logic                    mac_rxer_o;
	logic [`ETH_DATA_W-1:0]  mac_txdat_i;
	logic                    mac_txen_i;
	logic                    mac_txer_i;
	logic                    link_up_o;
	logic [`ETH_SPEED_W-1:0] speed_o;
	logic                    active_port_o;
	logic                    link_change_o;

	integer seed;
	int     edge_cnt = 0;
	int     waited;

	// Reference model state
	logic [1:0]              mdl_last_up;
	logic [1:0]              mdl_last_speed [2];
	int                      mdl_run [2];
	logic [1:0]              mdl_qual_up;
	logic [1:0]              mdl_qual_speed [2];
	logic                    exp_active;
	logic                    exp_link_up;
	logic [1:0]              exp_speed;
	logic                    exp_change;
	logic [`ETH_DATA_W-1:0]  exp_rxdat;
	logic                    exp_rxdv;
	logic                    exp_rxer;
	logic [1:0]              exp_txen;
	logic [1:0]              exp_txer;
	logic [`ETH_DATA_W-1:0]  exp_txdat [2];

	phy_failover_top uut (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reporting and waits

	task automatic flag_mismatch(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		$display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, act_val);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic flag_failure(input string msg);
		$display("At %0t ns: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic wait_link_up(input logic level, input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				flag_failure("link_up_o never reached the expected level before the timeout");
			end
		end while (link_up_o !== level);
	endtask

	task automatic wait_active_port(input logic port, input int limit);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				flag_failure("active_port_o never switched to the expected port in time");
			end
		end while (active_port_o !== port);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Random bytes on both PHYs, valid only on the ports in the mask
	task automatic drive_rx_frame(input logic [1:0] ports, input int len);
		int r;
		repeat (len) begin
			r = $random(seed);
			phy0_rxdat_i = r[7:0];
			phy1_rxdat_i = r[15:8];
			phy0_rxdv_i  = ports[0];
			phy1_rxdv_i  = ports[1];
			phy0_rxer_i  = ports[0] && (r[19:16] == 4'h0);
			phy1_rxer_i  = ports[1] && (r[23:20] == 4'h0);
			@(negedge clk);
		end
		phy0_rxdv_i = 1'b0;
		phy1_rxdv_i = 1'b0;
		phy0_rxer_i = 1'b0;
		phy1_rxer_i = 1'b0;
	endtask

	task automatic drive_tx_frame(input int len);
		int r;
		repeat (len) begin
			r = $random(seed);
			mac_txdat_i = r[7:0];
			mac_txen_i  = 1'b1;
			mac_txer_i  = (r[11:8] == 4'h0);
			@(negedge clk);
		end
		mac_txen_i = 1'b0;
		mac_txer_i = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model, one step per rising edge

	always @(posedge clk) begin : model_step
		logic [1:0] raw_up;
		logic [1:0] raw_speed [2];
		logic       cur_up;
		logic       other_up;
		logic       cur_dv;
		logic       nxt_active;
		logic       nxt_up;
		logic       sel;
		int         run;

		edge_cnt <= edge_cnt + 1;
		raw_up       = {phy1_up_i, phy0_up_i};
		raw_speed[0] = phy0_speed_i;
		raw_speed[1] = phy1_speed_i;
		if (reset_i) begin
			mdl_last_up <= 2'b00;
			mdl_qual_up <= 2'b00;
			for (int p = 0; p < 2; p++) begin
				mdl_last_speed[p] <= SPEED_10;
				mdl_qual_speed[p] <= SPEED_10;
				mdl_run[p]        <= 0;
				exp_txdat[p]      <= '0;
			end
			{exp_active, exp_link_up, exp_change} <= 3'b000;
			exp_speed <= SPEED_10;
			{exp_rxdat, exp_rxdv, exp_rxer} <= '0;
			exp_txen <= 2'b00;
			exp_txer <= 2'b00;
		end else begin
			// Debounce: a report is taken after a full stable run
			for (int p = 0; p < 2; p++) begin
				if (raw_up[p] == mdl_last_up[p] && raw_speed[p] == mdl_last_speed[p]) begin
					run = (mdl_run[p] < `LINK_STABLE_CYCLES) ? mdl_run[p] + 1 : mdl_run[p];
				end else begin
					run = 1;
				end
				mdl_run[p]        <= run;
				mdl_last_up[p]    <= raw_up[p];
				mdl_last_speed[p] <= raw_speed[p];
				if (run >= `LINK_STABLE_CYCLES) begin
					mdl_qual_up[p]    <= raw_up[p];
					mdl_qual_speed[p] <= raw_speed[p];
				end
			end

			// Sticky port choice, switch only between frames
			cur_up     = mdl_qual_up[exp_active];
			other_up   = mdl_qual_up[!exp_active];
			cur_dv     = exp_active ? phy1_rxdv_i : phy0_rxdv_i;
			nxt_active = (!cur_up && other_up && !cur_dv) ? !exp_active : exp_active;
			nxt_up     = mdl_qual_up[nxt_active];
			exp_active  <= nxt_active;
			exp_link_up <= nxt_up;
			exp_speed   <= nxt_up ? mdl_qual_speed[nxt_active] : SPEED_10;
			exp_change  <= (nxt_up != exp_link_up) || (nxt_active != exp_active);

			// Data stages use the state registered before this edge
			if (!exp_link_up) begin
				{exp_rxdat, exp_rxdv, exp_rxer} <= '0;
			end else if (exp_active) begin
				{exp_rxdat, exp_rxdv, exp_rxer} <= {phy1_rxdat_i, phy1_rxdv_i, phy1_rxer_i};
			end else begin
				{exp_rxdat, exp_rxdv, exp_rxer} <= {phy0_rxdat_i, phy0_rxdv_i, phy0_rxer_i};
			end
			for (int p = 0; p < 2; p++) begin
				sel = exp_link_up && (exp_active == p[0]);
				exp_txen[p]  <= sel && mac_txen_i;
				exp_txer[p]  <= sel && mac_txer_i;
				exp_txdat[p] <= sel ? mac_txdat_i : '0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output checks, from the third edge on

	a_link_up: assert property (@(posedge clk) edge_cnt >= 2 |-> link_up_o == exp_link_up)
		else flag_mismatch("link_up_o", $sampled(exp_link_up), $sampled(link_up_o));
	a_speed: assert property (@(posedge clk) edge_cnt >= 2 |-> speed_o == exp_speed)
		else flag_mismatch("speed_o", $sampled(exp_speed), $sampled(speed_o));
	a_active: assert property (@(posedge clk) edge_cnt >= 2 |-> active_port_o == exp_active)
		else flag_mismatch("active_port_o", $sampled(exp_active), $sampled(active_port_o));
	a_change: assert property (@(posedge clk) edge_cnt >= 2 |-> link_change_o == exp_change)
		else flag_mismatch("link_change_o", $sampled(exp_change), $sampled(link_change_o));
	a_rxdv: assert property (@(posedge clk) edge_cnt >= 2 |-> mac_rxdv_o == exp_rxdv)
		else flag_mismatch("mac_rxdv_o", $sampled(exp_rxdv), $sampled(mac_rxdv_o));
	a_rxer: assert property (@(posedge clk) edge_cnt >= 2 |-> mac_rxer_o == exp_rxer)
		else flag_mismatch("mac_rxer_o", $sampled(exp_rxer), $sampled(mac_rxer_o));
	a_rxdat: assert property (@(posedge clk) edge_cnt >= 2 |-> mac_rxdat_o == exp_rxdat)
		else flag_mismatch("mac_rxdat_o", $sampled(exp_rxdat), $sampled(mac_rxdat_o));
	a_tx0en: assert property (@(posedge clk) edge_cnt >= 2 |-> phy0_txen_o == exp_txen[0])
		else flag_mismatch("phy0_txen_o", $sampled(exp_txen[0]), $sampled(phy0_txen_o));
	a_tx0er: assert property (@(posedge clk) edge_cnt >= 2 |-> phy0_txer_o == exp_txer[0])
		else flag_mismatch("phy0_txer_o", $sampled(exp_txer[0]), $sampled(phy0_txer_o));
	a_tx0dat: assert property (@(posedge clk) edge_cnt >= 2 |-> phy0_txdat_o == exp_txdat[0])
		else flag_mismatch("phy0_txdat_o", $sampled(exp_txdat[0]), $sampled(phy0_txdat_o));
	a_tx1en: assert property (@(posedge clk) edge_cnt >= 2 |-> phy1_txen_o == exp_txen[1])
		else flag_mismatch("phy1_txen_o", $sampled(exp_txen[1]), $sampled(phy1_txen_o));
	a_tx1er: assert property (@(posedge clk) edge_cnt >= 2 |-> phy1_txer_o == exp_txer[1])
		else flag_mismatch("phy1_txer_o", $sampled(exp_txer[1]), $sampled(phy1_txer_o));
	a_tx1dat: assert property (@(posedge clk) edge_cnt >= 2 |-> phy1_txdat_o == exp_txdat[1])
		else flag_mismatch("phy1_txdat_o", $sampled(exp_txdat[1]), $sampled(phy1_txdat_o));

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		seed = 32'h0417438f;
		reset_i = 1'b1;
		{phy0_up_i, phy0_speed_i, phy0_rxdat_i, phy0_rxdv_i, phy0_rxer_i} = '0;
		{phy1_up_i, phy1_speed_i, phy1_rxdat_i, phy1_rxdv_i, phy1_rxer_i} = '0;
		{mac_txdat_i, mac_txen_i, mac_txer_i} = '0;
		idle_cycles(8);
		reset_i = 1'b0;
		idle_cycles(4);

		// Glitch shorter than the debounce window
		phy0_up_i    = 1'b1;
		phy0_speed_i = SPEED_1000;
		idle_cycles(`LINK_STABLE_CYCLES - 4);
		phy0_up_i    = 1'b0;
		phy0_speed_i = SPEED_10;
		idle_cycles(`LINK_STABLE_CYCLES + 4);

		// Stable link on port 0
		phy0_up_i    = 1'b1;
		phy0_speed_i = SPEED_1000;
		wait_link_up(1'b1, `LINK_STABLE_CYCLES + 8, waited);
		assert (waited == `LINK_STABLE_CYCLES + 1)
			else flag_mismatch("link_up_o latency", `LINK_STABLE_CYCLES + 1, waited);
		assert (link_change_o == 1'b1)
			else flag_mismatch("link_change_o", 1'b1, link_change_o);
		idle_cycles(2);

		// Traffic both ways, with noise on the idle port
		fork
			drive_rx_frame(2'b11, 24);
			drive_tx_frame(24);
		join
		idle_cycles(2);

		// Second port qualifies without taking over
		phy1_up_i    = 1'b1;
		phy1_speed_i = SPEED_100;
		idle_cycles(`LINK_STABLE_CYCLES + 4);

		// Port 0 fails in the middle of a long frame
		fork
			drive_rx_frame(2'b01, 3 * `LINK_STABLE_CYCLES);
			begin
				idle_cycles(2);
				phy0_up_i = 1'b0;
			end
		join
		assert (active_port_o == 1'b0)
			else flag_mismatch("active_port_o", 1'b0, active_port_o);
		wait_active_port(1'b1, 8);
		assert (link_change_o == 1'b1)
			else flag_mismatch("link_change_o", 1'b1, link_change_o);

		fork
			drive_rx_frame(2'b11, 16);
			drive_tx_frame(16);
		join

		// No return to port 0
		phy0_up_i = 1'b1;
		idle_cycles(`LINK_STABLE_CYCLES + 8);
		assert (active_port_o == 1'b1)
			else flag_mismatch("active_port_o", 1'b1, active_port_o);

		// Both links lost
		phy0_up_i = 1'b0;
		phy1_up_i = 1'b0;
		wait_link_up(1'b0, `LINK_STABLE_CYCLES + 8, waited);
		assert (speed_o == SPEED_10)
			else flag_mismatch("speed_o", SPEED_10, speed_o);
		fork
			drive_rx_frame(2'b11, 12);
			drive_tx_frame(12);
		join
		idle_cycles(4);

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+design
design/ethft_pkg.sv
design/link_status_if.sv
design/link_monitor.sv
design/port_arbiter.sv
design/rx_merge.sv
design/tx_steer.sv
design/phy_failover_top.sv
dv/tb_phy_failover.sv

// ==== Bender.yml ====
package:
  name: phy_failover

sources:
  - include_dirs:
      - design
    files:
      - design/ethft_pkg.sv
      - design/link_status_if.sv
      - design/link_monitor.sv
      - design/port_arbiter.sv
      - design/rx_merge.sv
      - design/tx_steer.sv
      - design/phy_failover_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_phy_failover.sv
